//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_processor
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qxF "$(PASS_MSG)" $(LOG) || { echo "simulation FAILED"; exit 1; }
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- decode_stage.sv
// Decode stage: field split, control decode, register read and the decode/execute latch
`timescale 1ns/100ps
`include "proc_config.svh"

module decode_stage (
    input  logic                   clock,
    input  logic                   arst_n,
    hazard_if.fetch_decode         hz,
    input  logic [`PROC_XLEN-1:0]  fd_pc,
    input  logic [`PROC_XLEN-1:0]  fd_ir,
    output logic [`PROC_REG_W-1:0] ctrl_read_reg_a,
    output logic [`PROC_REG_W-1:0] ctrl_read_reg_b,
    input  logic [`PROC_XLEN-1:0]  data_read_reg_a,
    input  logic [`PROC_XLEN-1:0]  data_read_reg_b,
    output proc_pkg::ctrl_t        dx_ctrl,
    output logic [`PROC_XLEN-1:0]  dx_pc,
    output logic [`PROC_XLEN-1:0]  dx_a,
    output logic [`PROC_XLEN-1:0]  dx_b,
    output logic [`PROC_XLEN-1:0]  dx_imm,
    output logic [`PROC_REG_W-1:0] dx_rs,
    output logic [`PROC_REG_W-1:0] dx_rt
);

    proc_pkg::opcode_e      opcode;
    logic [`PROC_REG_W-1:0] rd;
    logic [`PROC_REG_W-1:0] rs;
    logic [`PROC_REG_W-1:0] rt;
    logic [4:0]             fn;
    logic                   use_rd;
    proc_pkg::ctrl_t        ctrl;
    logic [`PROC_XLEN-1:0]  imm;

    assign opcode = proc_pkg::opcode_e'(fd_ir[31:27]);
    assign rd     = fd_ir[26:22];
    assign rs     = fd_ir[21:17];
    assign rt     = fd_ir[16:12];
    assign fn     = fd_ir[6:2];

    // bne and sw compare or store rd, so it goes out on port A
    assign use_rd          = (opcode == proc_pkg::OP_BNE) || (opcode == proc_pkg::OP_SW);
    assign ctrl_read_reg_a = use_rd ? rd : rs;
    assign ctrl_read_reg_b = use_rd ? rs : rt;

    // j target is zero-extended, everything else sign-extends the 17-bit field
    assign imm = (opcode == proc_pkg::OP_J) ?
                 {{(`PROC_XLEN-27){1'b0}}, fd_ir[26:0]} :
                 {{(`PROC_XLEN-17){fd_ir[16]}}, fd_ir[16:0]};

    // ----------------------------------------------------------------------
    // Control decode, unknown opcodes fall through as nops
    always_comb begin
        ctrl       = '0;
        ctrl.rd    = rd;
        ctrl.shamt = fd_ir[11:7];
        ctrl.aluop = proc_pkg::ALU_ADD;
        case (opcode)
            proc_pkg::OP_RTYPE: begin
                if (fn <= proc_pkg::ALU_MUL) begin   // Unused functions stay nops
                    ctrl.aluop  = proc_pkg::aluop_e'(fn);
                    ctrl.reg_we = 1'b1;
                    ctrl.is_mul = (fn == proc_pkg::ALU_MUL);
                end
            end
            proc_pkg::OP_ADDI: begin
                ctrl.use_imm = 1'b1;
                ctrl.reg_we  = 1'b1;
            end
            proc_pkg::OP_LW: begin
                ctrl.use_imm    = 1'b1;
                ctrl.reg_we     = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            proc_pkg::OP_SW: begin
                ctrl.use_imm = 1'b1;
                ctrl.mem_we  = 1'b1;
            end
            proc_pkg::OP_BNE: ctrl.is_bne  = 1'b1;
            proc_pkg::OP_J:   ctrl.is_jump = 1'b1;
            default: ;
        endcase
        if (rd == '0)
            ctrl.reg_we = 1'b0;   // r0 is never written, so never bypassed
    end

    // ----------------------------------------------------------------------
    // Decode/execute latch
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            dx_ctrl <= '0;
        else if (hz.flush)
            dx_ctrl <= '0;
        else if (!hz.stall_d)
            dx_ctrl <= ctrl;
    end

    always_ff @(posedge clock) begin
        if (!hz.stall_d) begin
            dx_pc  <= fd_pc;
            dx_a   <= data_read_reg_a;
            dx_b   <= data_read_reg_b;
            dx_imm <= imm;
            dx_rs  <= ctrl_read_reg_a;   // Actual read indices, for bypass compare
            dx_rt  <= ctrl_read_reg_b;
        end
    end

    a_no_r0_write: assert property (@(posedge clock) disable iff (!arst_n)
        dx_ctrl.reg_we |-> dx_ctrl.rd != '0);

endmodule

//--- execute_stage.sv
// Execute stage: operand bypass, ALU, branch and jump resolve, multiplier and execute/memory latch
`timescale 1ns/100ps
`include "proc_config.svh"

module execute_stage (
    input  logic                   clock,
    input  logic                   arst_n,
    hazard_if.execute              hz,
    input  proc_pkg::ctrl_t        dx_ctrl,
    input  logic [`PROC_XLEN-1:0]  dx_pc,
    input  logic [`PROC_XLEN-1:0]  dx_a,
    input  logic [`PROC_XLEN-1:0]  dx_b,
    input  logic [`PROC_XLEN-1:0]  dx_imm,
    input  logic [`PROC_REG_W-1:0] dx_rs,
    input  logic [`PROC_REG_W-1:0] dx_rt,
    input  logic [`PROC_XLEN-1:0]  q_dmem,
    input  logic [`PROC_XLEN-1:0]  wb_value,
    input  logic                   mul_start,
    output logic                   mul_ready,
    output logic [`PROC_XLEN-1:0]  redirect_pc,
    output proc_pkg::ctrl_t        xm_ctrl,
    output logic [`PROC_XLEN-1:0]  xm_result,
    output logic [`PROC_XLEN-1:0]  xm_store
);

    logic [`PROC_XLEN-1:0] op_a;
    logic [`PROC_XLEN-1:0] op_b;
    logic [`PROC_XLEN-1:0] alu_a;
    logic [`PROC_XLEN-1:0] alu_b;
    logic [`PROC_XLEN-1:0] alu_y;
    logic [`PROC_XLEN-1:0] product;

    function automatic logic [`PROC_XLEN-1:0] bypass(input proc_pkg::byp_sel_e sel,
                                                     input logic [`PROC_XLEN-1:0] reg_val);
        case (sel)
            proc_pkg::BYP_XM:   return xm_result;
            proc_pkg::BYP_LOAD: return q_dmem;     // Load one ahead, no stall needed
            proc_pkg::BYP_WB:   return wb_value;
            default:            return reg_val;
        endcase
    endfunction

    assign op_a = bypass(hz.sel_a, dx_a);
    assign op_b = bypass(hz.sel_b, dx_b);

    // sw carries store data on A and base on B
    assign alu_a = dx_ctrl.mem_we  ? op_b   : op_a;
    assign alu_b = dx_ctrl.use_imm ? dx_imm : op_b;

    always_comb begin
        case (dx_ctrl.aluop)
            proc_pkg::ALU_ADD: alu_y = alu_a + alu_b;   // Wraps
            proc_pkg::ALU_SUB: alu_y = alu_a - alu_b;
            proc_pkg::ALU_AND: alu_y = alu_a & alu_b;
            proc_pkg::ALU_OR:  alu_y = alu_a | alu_b;
            proc_pkg::ALU_SLL: alu_y = alu_a << dx_ctrl.shamt;
            proc_pkg::ALU_SRA: alu_y = $signed(alu_a) >>> dx_ctrl.shamt;
            default:           alu_y = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // Branch and jump, predicted not taken
    assign hz.redirect = (dx_ctrl.is_bne && (op_a != op_b)) || dx_ctrl.is_jump;
    assign redirect_pc = dx_ctrl.is_jump ? dx_imm
                                         : dx_pc + `PROC_XLEN'(1) + dx_imm;

    // Toward the hazard unit
    assign hz.x_rd     = dx_ctrl.rd;
    assign hz.x_we     = dx_ctrl.reg_we;
    assign hz.x_rs     = dx_rs;
    assign hz.x_rt     = dx_rt;
    assign hz.x_is_mul = dx_ctrl.is_mul;

    shift_add_multiplier mul_i (
        .clock        (clock),
        .arst_n       (arst_n),
        .start        (mul_start),
        .multiplicand (op_a),
        .multiplier   (op_b),
        .product      (product),
        .ready        (mul_ready)
    );

    // ----------------------------------------------------------------------
    // Execute/memory latch, bubble while the multiply holds execute
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            xm_ctrl <= '0;
        else if (hz.stall_x)
            xm_ctrl <= '0;
        else
            xm_ctrl <= dx_ctrl;
    end

    always_ff @(posedge clock) begin
        xm_result <= dx_ctrl.is_mul ? product : alu_y;  // Mul unstalled only in DONE
        xm_store  <= op_a;
    end

    a_no_redirect_in_stall: assert property (@(posedge clock) disable iff (!arst_n)
        hz.redirect |-> !hz.stall_x);

endmodule

//--- fetch_stage.sv
// Fetch stage: program counter, next-PC select and the fetch/decode latch
`timescale 1ns/100ps
`include "proc_config.svh"

module fetch_stage (
    input  logic                  clock,
    input  logic                  arst_n,
    hazard_if.fetch_decode        hz,
    input  logic [`PROC_XLEN-1:0] redirect_pc,
    output logic [`PROC_XLEN-1:0] address_imem,
    input  logic [`PROC_XLEN-1:0] q_imem,
    output logic [`PROC_XLEN-1:0] fd_pc,
    output logic [`PROC_XLEN-1:0] fd_ir
);

    logic [`PROC_XLEN-1:0] pc;

    assign address_imem = pc;  // Imem reads in the same cycle

    // Static not-taken, redirect from execute overrides
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            pc <= `PROC_XLEN'(`PROC_RESET_PC);
        else if (hz.flush)
            pc <= redirect_pc;
        else if (!hz.stall_f)
            pc <= pc + `PROC_XLEN'(1);
    end

    // ----------------------------------------------------------------------
    // Fetch/decode latch, all-zero word is a nop
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            fd_ir <= '0;
        else if (hz.flush)
            fd_ir <= '0;         // Squash the wrong-path fetch
        else if (!hz.stall_d)
            fd_ir <= q_imem;
    end

    always_ff @(posedge clock) begin
        if (!hz.stall_d)
            fd_pc <= pc;         // PC of the fetched word, not PC+1
    end

endmodule

//--- hazard_if.sv
// Hazard interface between the pipeline stages and the hazard unit
`timescale 1ns/100ps
`include "proc_config.svh"

interface hazard_if;

    // Execute stage
    logic [`PROC_REG_W-1:0] x_rd;
    logic [`PROC_REG_W-1:0] x_rs;
    logic [`PROC_REG_W-1:0] x_rt;
    logic                   x_we;
    logic                   x_is_mul;
    logic                   redirect;    // Taken bne or j

    // Memory and write-back stages
    logic [`PROC_REG_W-1:0] m_rd;
    logic [`PROC_REG_W-1:0] w_rd;
    logic                   m_we;
    logic                   m_is_load;
    logic                   w_we;

    // Hazard unit results
    proc_pkg::byp_sel_e     sel_a;
    proc_pkg::byp_sel_e     sel_b;
    logic                   stall_f;
    logic                   stall_d;
    logic                   stall_x;
    logic                   flush;

    modport execute (
        output x_rd, x_we, x_rs, x_rt, x_is_mul, redirect,
        input  sel_a, sel_b, stall_x
    );

    modport mem_wb (
        output m_rd, m_we, m_is_load, w_rd, w_we
    );

    modport fetch_decode (
        input stall_f, stall_d, flush
    );

    modport hazard (
        input  x_rd, x_we, x_rs, x_rt, x_is_mul, redirect,
        input  m_rd, m_we, m_is_load, w_rd, w_we,
        output sel_a, sel_b, stall_f, stall_d, stall_x, flush
    );

endinterface

//--- hazard_unit.sv
// Hazard unit that picks bypass sources, flushes on redirect and sequences multiplies
`timescale 1ns/100ps
`include "proc_config.svh"

module hazard_unit (
    input  logic  clock,
    input  logic  arst_n,
    hazard_if.hazard hz,
    output logic  mul_start,
    input  logic  mul_ready
);

    typedef enum logic [1:0] {
        S_RUN,
        S_BUSY,
        S_DONE
    } mul_state_e;

    mul_state_e state;
    mul_state_e state_nxt;
    logic       mul_stall;

    // Memory stage beats write-back and a load comes straight off the dmem bus
    function automatic proc_pkg::byp_sel_e pick(input logic [`PROC_REG_W-1:0] src);
        if (hz.m_we && (hz.m_rd == src))
            return hz.m_is_load ? proc_pkg::BYP_LOAD : proc_pkg::BYP_XM;
        if (hz.w_we && (hz.w_rd == src))
            return proc_pkg::BYP_WB;
        return proc_pkg::BYP_REG;
    endfunction

    assign hz.sel_a = pick(hz.x_rs);
    assign hz.sel_b = pick(hz.x_rt);
    assign hz.flush = hz.redirect;   // Kill fetch/decode and decode/execute

    // ----------------------------------------------------------------------
    // Multiply sequencer
    always_comb begin
        state_nxt = state;
        case (state)
            S_RUN:   if (hz.x_is_mul) state_nxt = S_BUSY;
            S_BUSY:  if (mul_ready)   state_nxt = S_DONE;
            default: state_nxt = S_RUN;   // DONE lasts one cycle
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            state <= S_RUN;
        else
            state <= state_nxt;
    end

    assign mul_start  = (state == S_RUN) && hz.x_is_mul;
    assign mul_stall  = mul_start || (state == S_BUSY);
    assign hz.stall_f = mul_stall;
    assign hz.stall_d = mul_stall;
    assign hz.stall_x = mul_stall;

    // The multiply is still parked in execute when its product lands
    a_done_holds_mul: assert property (@(posedge clock) disable iff (!arst_n)
        state == S_DONE |-> hz.x_is_mul);

endmodule

//--- mem_wb_stage.sv
// Memory and write-back stages: dmem drive, memory/write-back latch and register write select
`timescale 1ns/100ps
`include "proc_config.svh"

module mem_wb_stage (
    input  logic                   clock,
    input  logic                   arst_n,
    hazard_if.mem_wb               hz,
    input  proc_pkg::ctrl_t        xm_ctrl,
    input  logic [`PROC_XLEN-1:0]  xm_result,
    input  logic [`PROC_XLEN-1:0]  xm_store,
    output logic [`PROC_XLEN-1:0]  address_dmem,
    output logic [`PROC_XLEN-1:0]  data,
    output logic                   wren,
    input  logic [`PROC_XLEN-1:0]  q_dmem,
    output logic                   ctrl_write_enable,
    output logic [`PROC_REG_W-1:0] ctrl_write_reg,
    output logic [`PROC_XLEN-1:0]  data_write_reg
);

    proc_pkg::ctrl_t       mw_ctrl;
    logic [`PROC_XLEN-1:0] mw_result;
    logic [`PROC_XLEN-1:0] mw_load;

    // Dmem straight from the execute/memory latch
    assign address_dmem = xm_result;
    assign data         = xm_store;
    assign wren         = xm_ctrl.mem_we;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            mw_ctrl <= '0;
        else
            mw_ctrl <= xm_ctrl;   // Never stalls, drains under a multiply
    end

    always_ff @(posedge clock) begin
        mw_result <= xm_result;
        mw_load   <= q_dmem;
    end

    assign ctrl_write_enable = mw_ctrl.reg_we;
    assign ctrl_write_reg    = mw_ctrl.rd;
    assign data_write_reg    = mw_ctrl.mem_to_reg ? mw_load : mw_result;  // Also the WB bypass

    // Producers for the bypass compare
    assign hz.m_rd      = xm_ctrl.rd;
    assign hz.m_we      = xm_ctrl.reg_we;
    assign hz.m_is_load = xm_ctrl.mem_to_reg;
    assign hz.w_rd      = mw_ctrl.rd;
    assign hz.w_we      = mw_ctrl.reg_we;

endmodule

//--- proc_config.svh
// Processor configuration macros: word width, register index width, multiply steps, reset PC
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// Data path and address width
`define PROC_XLEN 32

// Register file index width
`define PROC_REG_W 5

// Shift-add iterations, one per product bit
`define PROC_MUL_STEPS 32

// First fetch address after reset
`define PROC_RESET_PC 0

`endif

//--- proc_pkg.sv
// Processor package with the opcode, ALU function, bypass select and control types
`include "proc_config.svh"

package proc_pkg;

    // Instruction opcodes, bits 31..27
    typedef enum logic [4:0] {
        OP_RTYPE = 5'b00000,
        OP_J     = 5'b00001,
        OP_BNE   = 5'b00010,
        OP_ADDI  = 5'b00101,
        OP_SW    = 5'b00111,
        OP_LW    = 5'b01000
    } opcode_e;

    // R-type function field, bits 6..2
    typedef enum logic [4:0] {
        ALU_ADD = 5'd0,
        ALU_SUB = 5'd1,
        ALU_AND = 5'd2,
        ALU_OR  = 5'd3,
        ALU_SLL = 5'd4,
        ALU_SRA = 5'd5,
        ALU_MUL = 5'd6
    } aluop_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        BYP_REG  = 2'd0,   // Value latched from the register file
        BYP_XM   = 2'd1,   // Execute/memory result
        BYP_LOAD = 2'd2,   // Data memory read data
        BYP_WB   = 2'd3    // Write-back value
    } byp_sel_e;

    // Decoded control, follows the instruction down the pipe
    typedef struct packed {
        logic [`PROC_REG_W-1:0] rd;
        logic [4:0]             shamt;
        aluop_e                 aluop;
        logic                   use_imm;     // ALU B from immediate
        logic                   reg_we;      // Writes rd
        logic                   mem_we;      // Store
        logic                   mem_to_reg;  // Load
        logic                   is_bne;
        logic                   is_jump;
        logic                   is_mul;
    } ctrl_t;

endpackage

//--- processor.sv
// Five-stage pipelined processor core with external imem, dmem and register file
`timescale 1ns/100ps
`include "proc_config.svh"

module processor (
    input  logic                   clock,
    input  logic                   arst_n,
    // Instruction memory
    output logic [`PROC_XLEN-1:0]  address_imem,
    input  logic [`PROC_XLEN-1:0]  q_imem,
    // Data memory
    output logic [`PROC_XLEN-1:0]  address_dmem,
    output logic [`PROC_XLEN-1:0]  data,
    output logic                   wren,
    input  logic [`PROC_XLEN-1:0]  q_dmem,
    // Register file
    output logic                   ctrl_write_enable,
    output logic [`PROC_REG_W-1:0] ctrl_write_reg,
    output logic [`PROC_REG_W-1:0] ctrl_read_reg_a,
    output logic [`PROC_REG_W-1:0] ctrl_read_reg_b,
    output logic [`PROC_XLEN-1:0]  data_write_reg,
    input  logic [`PROC_XLEN-1:0]  data_read_reg_a,
    input  logic [`PROC_XLEN-1:0]  data_read_reg_b
);

    logic [`PROC_XLEN-1:0]  redirect_pc;
    logic [`PROC_XLEN-1:0]  fd_pc;
    logic [`PROC_XLEN-1:0]  fd_ir;
    proc_pkg::ctrl_t        dx_ctrl;
    logic [`PROC_XLEN-1:0]  dx_pc;
    logic [`PROC_XLEN-1:0]  dx_a;
    logic [`PROC_XLEN-1:0]  dx_b;
    logic [`PROC_XLEN-1:0]  dx_imm;
    logic [`PROC_REG_W-1:0] dx_rs;
    logic [`PROC_REG_W-1:0] dx_rt;
    proc_pkg::ctrl_t        xm_ctrl;
    logic [`PROC_XLEN-1:0]  xm_result;
    logic [`PROC_XLEN-1:0]  xm_store;
    logic                   mul_start;
    logic                   mul_ready;

    hazard_if hz ();

    fetch_stage fetch_i (
        .clock, .arst_n, .hz(hz.fetch_decode),
        .redirect_pc, .address_imem, .q_imem, .fd_pc, .fd_ir
    );

    decode_stage decode_i (
        .clock, .arst_n, .hz(hz.fetch_decode),
        .fd_pc, .fd_ir,
        .ctrl_read_reg_a, .ctrl_read_reg_b, .data_read_reg_a, .data_read_reg_b,
        .dx_ctrl, .dx_pc, .dx_a, .dx_b, .dx_imm, .dx_rs, .dx_rt
    );

    execute_stage execute_i (
        .clock, .arst_n, .hz(hz.execute),
        .dx_ctrl, .dx_pc, .dx_a, .dx_b, .dx_imm, .dx_rs, .dx_rt,
        .q_dmem, .wb_value(data_write_reg), .mul_start, .mul_ready,
        .redirect_pc, .xm_ctrl, .xm_result, .xm_store
    );

    mem_wb_stage mem_wb_i (
        .clock, .arst_n, .hz(hz.mem_wb),
        .xm_ctrl, .xm_result, .xm_store,
        .address_dmem, .data, .wren, .q_dmem,
        .ctrl_write_enable, .ctrl_write_reg, .data_write_reg
    );

    hazard_unit hazard_i (
        .clock, .arst_n, .hz(hz.hazard), .mul_start, .mul_ready
    );

endmodule

//--- shift_add_multiplier.sv
// Iterative shift-add multiplier giving the low word of the product
`timescale 1ns/100ps
`include "proc_config.svh"

module shift_add_multiplier (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  start,
    input  logic [`PROC_XLEN-1:0] multiplicand,
    input  logic [`PROC_XLEN-1:0] multiplier,
    output logic [`PROC_XLEN-1:0] product,
    output logic                  ready
);

    localparam int CNT_W = $clog2(`PROC_MUL_STEPS + 1);

    logic [CNT_W-1:0]      count;     // Steps left, zero when idle
    logic [`PROC_XLEN-1:0] mcand;     // Shifted left each step
    logic [`PROC_XLEN-1:0] mplier;    // Shifted right each step
    logic [`PROC_XLEN-1:0] acc;

    assign product = acc;
    assign ready   = (count == '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n)
            count <= '0;
        else if (start)
            count <= CNT_W'(`PROC_MUL_STEPS - 1);   // First step taken on the start edge
        else if (count != '0)
            count <= count - 1'b1;
    end

    // Low word only, so signed and unsigned agree
    always_ff @(posedge clock) begin
        if (start) begin
            acc    <= multiplier[0] ? multiplicand : '0;
            mcand  <= multiplicand << 1;
            mplier <= multiplier >> 1;
        end else if (count != '0) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    a_start_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
        start |-> ready);

endmodule

//--- tb_processor.sv
// Testbench that runs a random program on the processor against a reference model
`timescale 1ns/100ps
`include "proc_config.svh"

module tb_processor;

    localparam int PROG_LEN     = 200;
    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 64;
    localparam int DRAIN_CYCLES = 20;
    localparam int CYCLE_LIMIT  = PROG_LEN * (`PROC_MUL_STEPS + 8) + 100;

    logic                   clock;
    logic                   arst_n;
    logic [`PROC_XLEN-1:0]  address_imem;
    logic [`PROC_XLEN-1:0]  q_imem;
    logic [`PROC_XLEN-1:0]  address_dmem;
    logic [`PROC_XLEN-1:0]  data;
    logic                   wren;
    logic [`PROC_XLEN-1:0]  q_dmem;
    logic                   ctrl_write_enable;
    logic [`PROC_REG_W-1:0] ctrl_write_reg;
    logic [`PROC_REG_W-1:0] ctrl_read_reg_a;
    logic [`PROC_REG_W-1:0] ctrl_read_reg_b;
    logic [`PROC_XLEN-1:0]  data_write_reg;
    logic [`PROC_XLEN-1:0]  data_read_reg_a;
    logic [`PROC_XLEN-1:0]  data_read_reg_b;

    logic [31:0] imem [IMEM_WORDS];       // Program padded with zeros
    logic [31:0] dmem [DMEM_WORDS];       // Live data memory model
    logic [31:0] rf [32];                 // Live register file model
    logic [31:0] init_rf [32];            // Start state shared with the reference
    logic [31:0] init_dmem [DMEM_WORDS];

    // Reference results in program order
    logic [4:0]  exp_wr_reg [$];
    logic [31:0] exp_wr_val [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];

    int wr_idx      = 0;
    int st_idx      = 0;
    int cycles      = 0;
    int since_reset = 0;

    processor processor_i (
        .clock             (clock),
        .arst_n            (arst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    always #5 clock = ~clock;   // 10 ns period

    // ----------------------------------------------------------------------
    // Reporting
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("Mismatch %s: expected 'h%h, actual 'h%h",
                                name, expected, actual));
    endtask

    // ----------------------------------------------------------------------
    // Instruction encoders in the ISA field layout
    function automatic logic [31:0] rtype_word(input logic [4:0] fn, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] shamt);
        return {proc_pkg::OP_RTYPE, rd, rs, rt, shamt, fn, 2'b00};
    endfunction

    function automatic logic [31:0] itype_word(input logic [4:0] op, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [16:0] imm);
        return {op, rd, rs, imm};
    endfunction

    task automatic build_program();
        int         kind;
        int         ahead;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = '0;                                  // All-zero word is a nop
        for (int i = 0; i < PROG_LEN; i++) begin
            kind  = $urandom_range(99, 0);
            rd    = 5'($urandom_range(7, 0));              // Few registers give many dependencies
            rs    = 5'($urandom_range(7, 0));
            rt    = 5'($urandom_range(7, 0));
            ahead = $urandom_range(8, 1);                  // Forward only
            if (kind < 40)
                imem[i] = rtype_word(5'($urandom_range(5, 0)), rd, rs, rt, 5'($urandom));
            else if (kind < 46)
                imem[i] = rtype_word(proc_pkg::ALU_MUL, rd, rs, rt, 5'd0);
            else if (kind < 62)
                imem[i] = itype_word(proc_pkg::OP_ADDI, rd, rs, 17'($urandom));
            else if (kind < 72)
                imem[i] = itype_word(proc_pkg::OP_LW, rd, 5'd0, 17'($urandom_range(63, 0)));
            else if (kind < 82)
                imem[i] = itype_word(proc_pkg::OP_SW, rd, 5'd0, 17'($urandom_range(63, 0)));
            else if (kind < 91)
                imem[i] = itype_word(proc_pkg::OP_BNE, rd, rs, 17'(ahead - 1));
            else
                imem[i] = {proc_pkg::OP_J, 27'(i + ahead)};  // Absolute target
        end
        init_rf[0] = '0;
        for (int r = 1; r < 32; r++)
            init_rf[r] = $urandom;
        for (int w = 0; w < DMEM_WORDS; w++)
            init_dmem[w] = $urandom;
    endtask

    // ----------------------------------------------------------------------
    // Instruction-set reference that runs one instruction at a time
    task automatic run_reference();
        logic [31:0] r [32];
        logic [31:0] m [DMEM_WORDS];
        logic [31:0] ir;
        logic [31:0] sext;
        logic [31:0] addr;
        logic [31:0] res;
        logic [4:0]  op;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic        writes;
        int          pc;
        int          npc;
        r  = init_rf;
        m  = init_dmem;
        pc = `PROC_RESET_PC;
        while (pc < PROG_LEN) begin
            ir     = imem[pc];
            op     = ir[31:27];
            rd     = ir[26:22];
            rs     = ir[21:17];
            rt     = ir[16:12];
            sext   = {{15{ir[16]}}, ir[16:0]};
            npc    = pc + 1;
            writes = 1'b0;
            res    = '0;
            case (op)
                proc_pkg::OP_RTYPE: begin
                    writes = 1'b1;
                    case (ir[6:2])
                        proc_pkg::ALU_ADD: res = r[rs] + r[rt];
                        proc_pkg::ALU_SUB: res = r[rs] - r[rt];
                        proc_pkg::ALU_AND: res = r[rs] & r[rt];
                        proc_pkg::ALU_OR:  res = r[rs] | r[rt];
                        proc_pkg::ALU_SLL: res = r[rs] << ir[11:7];
                        proc_pkg::ALU_SRA: res = $signed(r[rs]) >>> ir[11:7];
                        proc_pkg::ALU_MUL: res = r[rs] * r[rt];   // Low word
                        default:           writes = 1'b0;
                    endcase
                end
                proc_pkg::OP_ADDI: begin
                    res    = r[rs] + sext;
                    writes = 1'b1;
                end
                proc_pkg::OP_LW: begin
                    addr   = r[rs] + sext;
                    res    = m[addr[5:0]];
                    writes = 1'b1;
                end
                proc_pkg::OP_SW: begin
                    addr         = r[rs] + sext;
                    m[addr[5:0]] = r[rd];   // rd holds the store data
                    exp_st_addr.push_back(addr);
                    exp_st_data.push_back(r[rd]);
                end
                proc_pkg::OP_BNE: begin
                    if (r[rd] != r[rs])
                        npc = pc + 1 + int'(sext);
                end
                proc_pkg::OP_J: npc = int'(ir[26:0]);
                default: ;
            endcase
            if (writes && rd != 5'd0) begin
                r[rd] = res;
                exp_wr_reg.push_back(rd);
                exp_wr_val.push_back(res);
            end
            pc = npc;
        end
    endtask

    // ----------------------------------------------------------------------
    // Memory and register file models
    always_comb begin
        if (address_imem < IMEM_WORDS)
            q_imem = imem[address_imem[7:0]];
        else
            q_imem = '0;   // Nops past the array
    end

    always_comb q_dmem = dmem[address_dmem[5:0]];

    // A read of the register written this cycle sees the new value
    always_comb begin
        if (ctrl_write_enable && ctrl_write_reg != '0 && ctrl_write_reg == ctrl_read_reg_a)
            data_read_reg_a = data_write_reg;
        else
            data_read_reg_a = rf[ctrl_read_reg_a];
        if (ctrl_write_enable && ctrl_write_reg != '0 && ctrl_write_reg == ctrl_read_reg_b)
            data_read_reg_b = data_write_reg;
        else
            data_read_reg_b = rf[ctrl_read_reg_b];
    end

    always @(posedge clock) begin
        if (!arst_n) begin
            rf   <= init_rf;     // Loaded from the start state under reset
            dmem <= init_dmem;
        end else begin
            if (ctrl_write_enable && ctrl_write_reg != '0)
                rf[ctrl_write_reg] <= data_write_reg;
            if (wren)
                dmem[address_dmem[5:0]] <= data;
        end
    end

    // ----------------------------------------------------------------------
    // Cycle counters and the run limit
    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (arst_n)
            since_reset <= since_reset + 1;
        if (cycles >= CYCLE_LIMIT)
            abort_run("Program did not finish before the cycle limit was reached");
    end

    // Output checks at mid-cycle where the DUT outputs are settled
    always @(negedge clock) begin
        if (!arst_n || since_reset < 3)
            compare_value("idle wren", 32'd0, 32'(wren));
        if (!arst_n || since_reset < 4)
            compare_value("idle write enable", 32'd0, 32'(ctrl_write_enable));
        if (arst_n && since_reset == 0)
            compare_value("first fetch", `PROC_RESET_PC, address_imem);
        if (arst_n && ctrl_write_enable) begin
            if (wr_idx >= exp_wr_reg.size()) begin
                abort_run("Register write seen after the last expected write");
            end else begin
                compare_value($sformatf("write %0d register", wr_idx),
                              32'(exp_wr_reg[wr_idx]), 32'(ctrl_write_reg));
                compare_value($sformatf("write %0d value", wr_idx),
                              exp_wr_val[wr_idx], data_write_reg);
                wr_idx++;
            end
        end
        if (arst_n && wren) begin
            if (st_idx >= exp_st_addr.size()) begin
                abort_run("Store seen after the last expected store");
            end else begin
                compare_value($sformatf("store %0d address", st_idx),
                              exp_st_addr[st_idx], address_dmem);
                compare_value($sformatf("store %0d data", st_idx),
                              exp_st_data[st_idx], data);
                st_idx++;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Main sequence
    initial begin
        clock  = 1'b0;
        arst_n = 1'b0;
        void'($urandom(32'hbad9));   // One seed for the whole run
        build_program();
        run_reference();
        $display("Reference: %0d register writes, %0d stores",
                 exp_wr_reg.size(), exp_st_addr.size());
        repeat (16) @(posedge clock);
        arst_n <= 1'b1;
        // Every expected result seen and fetch is past the program
        while (!(wr_idx == exp_wr_reg.size() && st_idx == exp_st_addr.size()
                 && address_imem >= PROG_LEN))
            @(posedge clock);
        repeat (DRAIN_CYCLES) @(posedge clock);   // Catch late extra writes or stores
        $display("all tests passed");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
proc_pkg.sv
hazard_if.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
shift_add_multiplier.sv
hazard_unit.sv
mem_wb_stage.sv
processor.sv
tb_processor.sv
